// ==== usb_tx_pkg.sv ====
package usb_tx_pkg;

  // Bus and PID widths
  typedef logic [7:0] usb_byte_t;
  typedef logic [3:0] pid_code_t;
  typedef logic [15:0] crc16_t;

  // Kind codes form the upper half of their PID codes
  typedef logic [1:0] hsk_kind_t;
  typedef logic [1:0] tok_kind_t;
  typedef logic [1:0] dat_kind_t;

  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  typedef struct packed {
    tok_kind_t kind;
    usb_addr_t addr;
    usb_endp_t endp;
  } tok_req_t;

  // Holds {crc5, endp, addr} and goes out low byte first
  typedef logic [15:0] tok_field_t;

  typedef struct packed {
    usb_byte_t data;
    logic      last;
  } enc_byte_t;

  localparam int unsigned TX_FIFO_DEPTH = 4;

  typedef logic [$clog2(TX_FIFO_DEPTH+1)-1:0] credit_t;
  typedef logic [$clog2(TX_FIFO_DEPTH)-1:0] fifo_ptr_t;

  // PID byte carries the code and its complement
  function automatic usb_byte_t pid_byte(input pid_code_t code);
    return {~code, code};
  endfunction

  // Token CRC5 over {endp, addr} with bit 0 on the wire first
  function automatic logic [4:0] crc5_token(input logic [10:0] bits);
    logic [4:0] crc;
    logic [4:0] res;
    logic       fb;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb  = crc[4] ^ bits[i];
      crc = {crc[3:0], 1'b0};
      if (fb) begin
        crc = crc ^ 5'b00101;
      end
    end
    // Inverted and reversed so the MSB lands in the first wire bit
    for (int i = 0; i < 5; i++) begin
      res[i] = ~crc[4-i];
    end
    return res;
  endfunction

  // One byte of CRC16 taken LSB first
  function automatic crc16_t crc16_update(input usb_byte_t data, input crc16_t crc);
    crc16_t c;
    logic   fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h8005;
      end
    end
    return c;
  endfunction

endpackage

// ==== usb_token_former.sv ====
`timescale 1ns/1ns

module usb_token_former
  import usb_tx_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  logic       tok_req_valid_i,
  input  tok_req_t   tok_req_i,
  output logic       tok_req_ready_o,

  input  logic       tok_done_i,
  output logic       tok_send_o,
  output tok_kind_t  tok_kind_o,
  output tok_field_t tok_field_o
);

  logic       send_q;
  tok_kind_t  kind_q;
  tok_field_t field_q;
  logic       accept;

  // One request in flight at a time
  assign tok_req_ready_o = !send_q;
  assign accept          = tok_req_valid_i && !send_q;

  assign tok_send_o  = send_q;
  assign tok_kind_o  = kind_q;
  assign tok_field_o = field_q;

  // Send level held until the encoder reports the token done
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (accept) begin
      send_q <= 1'b1;
    end else if (tok_done_i) begin
      send_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      kind_q  <= tok_req_i.kind;
      field_q <= {crc5_token({tok_req_i.endp, tok_req_i.addr}),
                  tok_req_i.endp,
                  tok_req_i.addr};
    end
  end

endmodule

// ==== usb_packet_encoder.sv ====
`timescale 1ns/1ns

module usb_packet_encoder
  import usb_tx_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  // Handshake request
  input  logic       hsk_send_i,
  input  hsk_kind_t  hsk_kind_i,
  output logic       hsk_done_o,

  // Token request from the token former
  input  logic       tok_send_i,
  input  tok_kind_t  tok_kind_i,
  input  tok_field_t tok_field_i,
  output logic       tok_done_o,

  // Data packet request and payload stream
  input  logic       trn_tsend_i,
  input  dat_kind_t  trn_kind_i,
  output logic       trn_tdone_o,
  input  logic       trn_tvalid_i,
  output logic       trn_tready_o,
  input  logic       trn_tlast_i,
  input  usb_byte_t  trn_tdata_i,

  // Credit-controlled push into the byte FIFO
  output logic       push_valid_o,
  output enc_byte_t  push_byte_o,
  input  logic       credit_return_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HSK,
    ST_TOK,
    ST_DATA,
    ST_CRC
  } enc_state_e;

  enc_state_e state_q;
  logic [1:0] idx_q;
  logic       zero_q;
  credit_t    credit_q;
  logic       hsk_done_q;
  logic       tok_done_q;
  logic       trn_done_q;

  usb_byte_t  pid_q;
  crc16_t     crc_q;
  crc16_t     crc_tx;
  logic       has_credit;
  logic       done_any;

  assign has_credit = (credit_q != '0);
  assign done_any   = hsk_done_q || tok_done_q || trn_done_q;

  assign hsk_done_o  = hsk_done_q;
  assign tok_done_o  = tok_done_q;
  assign trn_tdone_o = trn_done_q;

  // CRC16 goes out complemented and bit reversed
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_tx[i] = ~crc_q[15-i];
    end
  end

  // Byte selection per state where idx_q counts bytes inside a state
  always_comb begin
    push_valid_o     = 1'b0;
    push_byte_o.data = pid_q;
    push_byte_o.last = 1'b0;
    trn_tready_o     = 1'b0;
    case (state_q)
      ST_HSK: begin
        push_valid_o     = has_credit;
        push_byte_o.last = 1'b1;
      end
      ST_TOK: begin
        push_valid_o = has_credit;
        if (idx_q == 2'd1) begin
          push_byte_o.data = tok_field_i[7:0];
        end else if (idx_q == 2'd2) begin
          push_byte_o.data = tok_field_i[15:8];
          push_byte_o.last = 1'b1;
        end
      end
      ST_DATA: begin
        if (idx_q == 2'd0) begin
          push_valid_o = has_credit;
        end else begin
          // Payload passes straight through while credits last
          trn_tready_o     = has_credit;
          push_valid_o     = has_credit && trn_tvalid_i;
          push_byte_o.data = trn_tdata_i;
        end
      end
      ST_CRC: begin
        push_valid_o = has_credit;
        if (idx_q == 2'd0) begin
          push_byte_o.data = crc_tx[7:0];
        end else begin
          push_byte_o.data = crc_tx[15:8];
          push_byte_o.last = 1'b1;
        end
      end
      default: begin
        push_valid_o = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ST_IDLE;
      idx_q      <= 2'd0;
      zero_q     <= 1'b0;
      credit_q   <= credit_t'(TX_FIFO_DEPTH);
      hsk_done_q <= 1'b0;
      tok_done_q <= 1'b0;
      trn_done_q <= 1'b0;
    end else begin
      hsk_done_q <= 1'b0;
      tok_done_q <= 1'b0;
      trn_done_q <= 1'b0;

      case ({push_valid_o, credit_return_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase

      case (state_q)
        ST_IDLE: begin
          idx_q <= 2'd0;
          // Requesters still see their done pulse, so skip this cycle
          if (!done_any) begin
            if (hsk_send_i) begin
              state_q <= ST_HSK;
            end else if (tok_send_i) begin
              state_q <= ST_TOK;
            end else if (trn_tsend_i) begin
              state_q <= ST_DATA;
              zero_q  <= trn_tlast_i && !trn_tvalid_i;
            end
          end
        end
        ST_HSK: begin
          if (push_valid_o) begin
            state_q    <= ST_IDLE;
            hsk_done_q <= 1'b1;
          end
        end
        ST_TOK: begin
          if (push_valid_o) begin
            if (idx_q == 2'd2) begin
              state_q    <= ST_IDLE;
              tok_done_q <= 1'b1;
            end else begin
              idx_q <= idx_q + 2'd1;
            end
          end
        end
        ST_DATA: begin
          if (push_valid_o) begin
            if (idx_q == 2'd0 && !zero_q) begin
              idx_q <= 2'd1;
            end else if (idx_q == 2'd0 || trn_tlast_i) begin
              state_q <= ST_CRC;
              idx_q   <= 2'd0;
            end
          end
        end
        ST_CRC: begin
          if (push_valid_o) begin
            if (idx_q == 2'd0) begin
              idx_q <= 2'd1;
            end else begin
              state_q    <= ST_IDLE;
              trn_done_q <= 1'b1;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // PID latched at the start of a packet and CRC run over the payload only
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE) begin
      crc_q <= 16'hffff;
      if (hsk_send_i) begin
        pid_q <= pid_byte({hsk_kind_i, 2'b10});
      end else if (tok_send_i) begin
        pid_q <= pid_byte({tok_kind_i, 2'b01});
      end else begin
        pid_q <= pid_byte({trn_kind_i, 2'b11});
      end
    end else if (state_q == ST_DATA && idx_q != 2'd0 && push_valid_o) begin
      crc_q <= crc16_update(trn_tdata_i, crc_q);
    end
  end

endmodule

// ==== usb_tx_byte_fifo.sv ====
`timescale 1ns/1ns

module usb_tx_byte_fifo
  import usb_tx_pkg::*;
(
  input  logic      clock,
  input  logic      reset,

  input  logic      push_valid_i,
  input  enc_byte_t push_byte_i,
  output logic      credit_return_o,

  output logic      fifo_valid_o,
  output enc_byte_t fifo_byte_o,
  input  logic      fifo_pop_i
);

  enc_byte_t mem [TX_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  credit_t   count_q;
  logic      credit_q;
  logic      do_push;
  logic      do_pop;

  // A push lands only while a slot is free
  assign do_push = push_valid_i && (count_q != credit_t'(TX_FIFO_DEPTH));
  assign do_pop  = fifo_pop_i && fifo_valid_o;

  // Head byte shows as soon as it is written
  assign fifo_valid_o    = (count_q != '0);
  assign fifo_byte_o     = mem[rd_ptr_q];
  assign credit_return_o = credit_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= do_pop;
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_t'(TX_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_t'(TX_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_byte_i;
    end
  end

endmodule

// ==== usb_ulpi_tx.sv ====
`timescale 1ns/1ns

module usb_ulpi_tx
  import usb_tx_pkg::*;
(
  input  logic      clock,
  input  logic      reset,

  input  logic      fifo_valid_i,
  input  enc_byte_t fifo_byte_i,
  output logic      fifo_pop_o,

  input  logic      ulpi_nxt_i,
  output usb_byte_t ulpi_data_o,
  output logic      ulpi_stp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TXCMD,
    ST_DATA,
    ST_STOP
  } ulpi_state_e;

  // TXCMD prefix for a transmit with PID
  localparam logic [3:0] TXCMD_PREFIX = 4'b0100;

  ulpi_state_e state_q;
  logic        accept;

  // A byte leaves the FIFO only when the PHY takes it
  assign accept = fifo_valid_i && ulpi_nxt_i &&
                  (state_q == ST_TXCMD || state_q == ST_DATA);

  always_comb begin
    ulpi_data_o = 8'h00;
    ulpi_stp_o  = 1'b0;
    fifo_pop_o  = accept;
    case (state_q)
      ST_TXCMD: begin
        // First byte of a packet is the PID, rewritten as a TXCMD
        ulpi_data_o = {TXCMD_PREFIX, fifo_byte_i.data[3:0]};
      end
      ST_DATA: begin
        if (fifo_valid_i) begin
          ulpi_data_o = fifo_byte_i.data;
        end
      end
      ST_STOP: begin
        ulpi_stp_o = 1'b1;
      end
      default: begin
        ulpi_data_o = 8'h00;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (fifo_valid_i) begin
            state_q <= ST_TXCMD;
          end
        end
        ST_TXCMD, ST_DATA: begin
          if (accept) begin
            state_q <= fifo_byte_i.last ? ST_STOP : ST_DATA;
          end
        end
        ST_STOP: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== usb_tx_top.sv ====
`timescale 1ns/1ns

module usb_tx_top
  import usb_tx_pkg::*;
(
  input  logic      clock,
  input  logic      reset,

  input  logic      hsk_send_i,
  input  hsk_kind_t hsk_kind_i,
  output logic      hsk_done_o,

  input  logic      trn_tsend_i,
  input  dat_kind_t trn_kind_i,
  output logic      trn_tdone_o,
  input  logic      trn_tvalid_i,
  output logic      trn_tready_o,
  input  logic      trn_tlast_i,
  input  usb_byte_t trn_tdata_i,

  input  logic      tok_req_valid_i,
  input  tok_req_t  tok_req_i,
  output logic      tok_req_ready_o,

  input  logic      ulpi_nxt_i,
  output usb_byte_t ulpi_data_o,
  output logic      ulpi_stp_o
);

  logic       tok_send;
  tok_kind_t  tok_kind;
  tok_field_t tok_field;
  logic       tok_done;

  logic       push_valid;
  enc_byte_t  push_byte;
  logic       credit_return;

  logic       fifo_valid;
  enc_byte_t  fifo_byte;
  logic       fifo_pop;

  usb_token_former u_token_former (
    .clock           (clock),
    .reset           (reset),
    .tok_req_valid_i (tok_req_valid_i),
    .tok_req_i       (tok_req_i),
    .tok_req_ready_o (tok_req_ready_o),
    .tok_done_i      (tok_done),
    .tok_send_o      (tok_send),
    .tok_kind_o      (tok_kind),
    .tok_field_o     (tok_field)
  );

  usb_packet_encoder u_encoder (
    .clock           (clock),
    .reset           (reset),
    .hsk_send_i      (hsk_send_i),
    .hsk_kind_i      (hsk_kind_i),
    .hsk_done_o      (hsk_done_o),
    .tok_send_i      (tok_send),
    .tok_kind_i      (tok_kind),
    .tok_field_i     (tok_field),
    .tok_done_o      (tok_done),
    .trn_tsend_i     (trn_tsend_i),
    .trn_kind_i      (trn_kind_i),
    .trn_tdone_o     (trn_tdone_o),
    .trn_tvalid_i    (trn_tvalid_i),
    .trn_tready_o    (trn_tready_o),
    .trn_tlast_i     (trn_tlast_i),
    .trn_tdata_i     (trn_tdata_i),
    .push_valid_o    (push_valid),
    .push_byte_o     (push_byte),
    .credit_return_i (credit_return)
  );

  usb_tx_byte_fifo u_fifo (
    .clock           (clock),
    .reset           (reset),
    .push_valid_i    (push_valid),
    .push_byte_i     (push_byte),
    .credit_return_o (credit_return),
    .fifo_valid_o    (fifo_valid),
    .fifo_byte_o     (fifo_byte),
    .fifo_pop_i      (fifo_pop)
  );

  usb_ulpi_tx u_ulpi_tx (
    .clock        (clock),
    .reset        (reset),
    .fifo_valid_i (fifo_valid),
    .fifo_byte_i  (fifo_byte),
    .fifo_pop_o   (fifo_pop),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_o  (ulpi_data_o),
    .ulpi_stp_o   (ulpi_stp_o)
  );

endmodule

// ==== usb_tx_assertions.sv ====
`timescale 1ns/1ns

module usb_tx_assertions
  import usb_tx_pkg::*;
(
  input logic    clock,
  input logic    reset,
  input credit_t credit_i,
  input logic    push_valid_i,
  input logic    credit_return_i
);

  int unsigned error_count = 0;

  // Credit count never above the FIFO depth
  a_credit_max: assert property (@(posedge clock) disable iff (reset)
    credit_i <= credit_t'(TX_FIFO_DEPTH))
  else begin
    error_count++;
    $error("credit count %0d above FIFO depth", credit_i);
  end

  // Every push spends a credit that exists
  a_push_needs_credit: assert property (@(posedge clock) disable iff (reset)
    push_valid_i |-> credit_i != '0)
  else begin
    error_count++;
    $error("push with no credit left");
  end

  // A returned credit never finds the counter full
  a_no_extra_credit: assert property (@(posedge clock) disable iff (reset)
    (credit_return_i && !push_valid_i) |-> credit_i != credit_t'(TX_FIFO_DEPTH))
  else begin
    error_count++;
    $error("credit returned while the counter is full");
  end

endmodule

bind usb_packet_encoder usb_tx_assertions u_assertions (
  .clock           (clock),
  .reset           (reset),
  .credit_i        (credit_q),
  .push_valid_i    (push_valid_o),
  .credit_return_i (credit_return_i)
);

// ==== tb_usb_tx.sv ====
`timescale 1ns/1ns

module tb_usb_tx
  import usb_tx_pkg::*;
();

  localparam int WAIT_LIMIT = 3000;

  logic      clock = 1'b0;
  logic      reset;
  logic      hsk_send_i;
  hsk_kind_t hsk_kind_i;
  logic      hsk_done_o;
  logic      trn_tsend_i;
  dat_kind_t trn_kind_i;
  logic      trn_tdone_o;
  logic      trn_tvalid_i;
  logic      trn_tready_o;
  logic      trn_tlast_i;
  usb_byte_t trn_tdata_i;
  logic      tok_req_valid_i;
  tok_req_t  tok_req_i;
  logic      tok_req_ready_o;
  logic      ulpi_nxt_i = 1'b1;
  usb_byte_t ulpi_data_o;
  logic      ulpi_stp_o;

  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned timeouts = 0;
  int unsigned assert_fails = 0;
  int unsigned pkt_count = 0;
  usb_byte_t   cap_q[$];
  usb_byte_t   exp_q[$];
  logic        in_pkt = 1'b0;
  logic        bp_mode = 1'b0;
  logic        nxt_level = 1'b0;
  logic [31:0] rng = 32'd56;
  int unsigned run_left = 0;

  usb_tx_top dut (.*);

  initial begin
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic crc16_t reverse16(input crc16_t v);
    crc16_t r;
    for (int i = 0; i < 16; i++) begin
      r[i] = v[15-i];
    end
    return r;
  endfunction

  // TXCMD is the transmit prefix with the PID code
  function automatic usb_byte_t txcmd_byte(input pid_code_t code);
    return {4'b0100, code};
  endfunction

  // PHY model drives nxt either always high or in random runs
  always @(negedge clock) begin
    if (!bp_mode) begin
      ulpi_nxt_i = 1'b1;
    end else begin
      if (run_left == 0) begin
        rng       = xorshift32(rng);
        nxt_level = !nxt_level;
        run_left  = nxt_level ? 1 + rng % 3 : 4 + rng % 12;
      end
      run_left   = run_left - 1;
      ulpi_nxt_i = nxt_level;
    end
  end

  // Bytes taken by the PHY where a packet opens on its TXCMD and closes on stp
  always @(posedge clock) begin
    if (reset) begin
      in_pkt = 1'b0;
    end else if (in_pkt) begin
      if (ulpi_stp_o) begin
        in_pkt    = 1'b0;
        pkt_count = pkt_count + 1;
      end else if (ulpi_nxt_i) begin
        cap_q.push_back(ulpi_data_o);
      end
    end else if (ulpi_nxt_i && !ulpi_stp_o && ulpi_data_o != 8'h00) begin
      in_pkt = 1'b1;
      cap_q.push_back(ulpi_data_o);
    end
  end

  task automatic check_byte(input string name, input usb_byte_t got, input usb_byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input integer got, input integer exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_done(input string name, input logic seen);
    checks++;
    if (!seen) begin
      errors++;
      $display("No %s pulse was seen within %0d cycles", name, WAIT_LIMIT);
    end
  endtask

  task automatic wait_packet_end(input int unsigned start, input string what);
    int cycles;
    cycles = 0;
    while (pkt_count == start && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (pkt_count == start) begin
      timeouts++;
      $display("Timeout while waiting for stp at the end of packet %s", what);
    end
  endtask

  task automatic compare_packet(input string what);
    check_count({"length of packet ", what}, cap_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size() && i < cap_q.size(); i++) begin
      check_byte($sformatf("ulpi_data_o %s byte %0d", what, i), cap_q[i], exp_q[i]);
    end
  endtask

  task automatic send_handshake(input hsk_kind_t kind, input string what);
    int unsigned start;
    int          cycles;
    logic        seen;
    start = pkt_count;
    cap_q.delete();
    exp_q.delete();
    exp_q.push_back(txcmd_byte({kind, 2'b10}));
    hsk_kind_i = kind;
    hsk_send_i = 1'b1;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
      seen = hsk_done_o;
    end
    hsk_send_i = 1'b0;
    check_done("hsk_done_o", seen);
    wait_packet_end(start, what);
    compare_packet(what);
  endtask

  task automatic send_token(input tok_kind_t kind, input usb_addr_t addr,
                            input usb_endp_t endp, input string what);
    int unsigned start;
    int          cycles;
    logic        taken;
    tok_field_t  field;
    start = pkt_count;
    cap_q.delete();
    exp_q.delete();
    field = {crc5_token({endp, addr}), endp, addr};
    exp_q.push_back(txcmd_byte({kind, 2'b01}));
    exp_q.push_back(field[7:0]);
    exp_q.push_back(field[15:8]);
    tok_req_i.kind  = kind;
    tok_req_i.addr  = addr;
    tok_req_i.endp  = endp;
    tok_req_valid_i = 1'b1;
    taken  = 1'b0;
    cycles = 0;
    // Ready seen here holds through the next rising edge
    while (!taken && cycles < WAIT_LIMIT) begin
      taken = tok_req_ready_o;
      @(negedge clock);
      cycles++;
    end
    tok_req_valid_i = 1'b0;
    check_done("tok_req_ready_o", taken);
    wait_packet_end(start, what);
    compare_packet(what);
  endtask

  task automatic send_data(input dat_kind_t kind, input int len, input usb_byte_t base,
                           input string what);
    int unsigned start;
    int          cycles;
    int          idx;
    logic        seen;
    logic        fire;
    usb_byte_t   payload[$];
    crc16_t      crc;
    start = pkt_count;
    cap_q.delete();
    exp_q.delete();
    exp_q.push_back(txcmd_byte({kind, 2'b11}));
    crc = 16'hffff;
    for (int i = 0; i < len; i++) begin
      payload.push_back(usb_byte_t'(base + i * 29));
      exp_q.push_back(payload[i]);
      crc = crc16_update(payload[i], crc);
    end
    // Complemented CRC goes out bit reversed, low byte first
    crc = ~reverse16(crc);
    exp_q.push_back(crc[7:0]);
    exp_q.push_back(crc[15:8]);
    trn_kind_i   = kind;
    trn_tsend_i  = 1'b1;
    trn_tvalid_i = (len > 0);
    trn_tlast_i  = (len <= 1);
    trn_tdata_i  = (len > 0) ? payload[0] : 8'h00;
    idx    = 0;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      // Ready only moves on a rising edge
      fire = trn_tvalid_i && trn_tready_o;
      @(negedge clock);
      cycles++;
      seen = trn_tdone_o;
      if (fire) begin
        idx++;
        if (idx < len) begin
          trn_tdata_i = payload[idx];
          trn_tlast_i = (idx == len - 1);
        end else begin
          trn_tvalid_i = 1'b0;
          trn_tlast_i  = 1'b0;
        end
      end
    end
    trn_tsend_i  = 1'b0;
    trn_tvalid_i = 1'b0;
    trn_tlast_i  = 1'b0;
    check_done("trn_tdone_o", seen);
    check_count({"payload bytes taken for ", what}, idx, len);
    wait_packet_end(start, what);
    compare_packet(what);
  endtask

  task automatic test_handshakes();
    send_handshake(2'b00, "ACK");
    send_handshake(2'b10, "NAK");
    send_handshake(2'b11, "STALL");
  endtask

  task automatic test_tokens();
    send_token(2'b10, 7'h05, 4'h1, "IN");
    send_token(2'b00, 7'h3a, 4'h0, "OUT");
    send_token(2'b11, 7'h7f, 4'hf, "SETUP");
    // SOF carries the frame number in the same 11 bits
    send_token(2'b01, 7'h2d, 4'h6, "SOF");
  endtask

  task automatic test_data_packets(input string tag);
    int lens [3];
    lens = '{1, 5, 12};
    for (int i = 0; i < 3; i++) begin
      send_data(2'b00, lens[i], usb_byte_t'(8'h40 + i),
                $sformatf("%sDATA0 len %0d", tag, lens[i]));
      send_data(2'b10, lens[i], usb_byte_t'(8'hc3 + i),
                $sformatf("%sDATA1 len %0d", tag, lens[i]));
    end
  endtask

  task automatic test_zero_length();
    send_data(2'b10, 0, 8'h00, "DATA1 len 0");
  endtask

  task automatic test_back_pressure();
    @(posedge clock);
    bp_mode = 1'b1;
    @(negedge clock);
    test_data_packets("stalled ");
    @(posedge clock);
    bp_mode = 1'b0;
    @(negedge clock);
  endtask

  initial begin
    reset           = 1'b1;
    hsk_send_i      = 1'b0;
    hsk_kind_i      = '0;
    trn_tsend_i     = 1'b0;
    trn_kind_i      = '0;
    trn_tvalid_i    = 1'b0;
    trn_tlast_i     = 1'b0;
    trn_tdata_i     = '0;
    tok_req_valid_i = 1'b0;
    tok_req_i       = '0;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    check_byte("ulpi_data_o after reset", ulpi_data_o, 8'h00);
    check_count("trn_tready_o after reset", trn_tready_o, 0);
    test_handshakes();
    test_tokens();
    test_data_packets("");
    test_zero_length();
    test_back_pressure();
    repeat (2) @(negedge clock);
    assert_fails = dut.u_encoder.u_assertions.error_count;
    $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
usb_tx_pkg.sv
usb_token_former.sv
usb_packet_encoder.sv
usb_tx_byte_fifo.sv
usb_ulpi_tx.sv
usb_tx_top.sv
usb_tx_assertions.sv
tb_usb_tx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the USB transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_tx -f all.f

./obj_dir/Vtb_usb_tx +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1
